// File: rtl/coherence_pkg.sv
// ----------------------------------------
// coherence package
// shared types and sizes for the memory bus
// ----------------------------------------

package coherence_pkg;

  // core count, protocol assumes exactly two
  localparam int CPUS = 2;

  // data and address widths
  localparam int WORD_W = 32;
  localparam int ADDR_W = 32;

  // ram depth in words, index from addr[9:2]
  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  // cycles a request is held before it completes
  localparam int RAM_LAT = 2;
  localparam int LAT_W   = $clog2(RAM_LAT + 1);

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // access = request completes this cycle
  typedef enum logic [1:0] {
    FREE,
    BUSY,
    ACCESS,
    ERROR
  } ramstate_t;

  // bus controller states
  typedef enum logic [2:0] {
    IDLE,
    IFETCH,
    SNOOP,
    XFER,
    XFER_WB,
    MEM_RD,
    WB
  } mc_state_t;

endpackage

// File: rtl/ram_model.sv
// ----------------------------------------
// ram model
// word ram with a fixed access latency
// ----------------------------------------

module ram_model (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     ramren,
  input  logic                     ramwen,
  input  coherence_pkg::addr_t     ramaddr,
  input  coherence_pkg::word_t     ramstore,
  output coherence_pkg::word_t     ramload,
  output coherence_pkg::ramstate_t ramstate
);

  import coherence_pkg::*;

  word_t             mem [RAM_WORDS];
  logic [RAM_AW-1:0] idx;

  // latency tracking
  logic [LAT_W-1:0]  cnt;
  logic [LAT_W-1:0]  held;
  addr_t             last_addr;
  logic              last_ren;
  logic              last_wen;
  logic              req;
  logic              changed;
  logic              access;

  assign idx     = ramaddr[RAM_AW+1:2];
  // exactly one of read or write
  assign req     = ramren ^ ramwen;
  assign changed = (ramaddr != last_addr) || (ramren != last_ren) || (ramwen != last_wen);
  // cycles held so far, this one included
  assign held    = changed ? LAT_W'(1) : cnt + 1'b1;
  assign access  = req && (held == LAT_W'(RAM_LAT));
  assign ramload = mem[idx];

  always_comb begin
    if (ramren && ramwen) begin
      ramstate = ERROR;
    end else if (access) begin
      ramstate = ACCESS;
    end else if (req) begin
      ramstate = BUSY;
    end else begin
      ramstate = FREE;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt       <= '0;
      last_addr <= '0;
      last_ren  <= 1'b0;
      last_wen  <= 1'b0;
    end else begin
      last_addr <= ramaddr;
      last_ren  <= ramren;
      last_wen  <= ramwen;
      // a held request starts over after it completes
      cnt       <= (access || !req) ? '0 : held;
    end
  end

  // write lands at the edge ending the access cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (access && ramwen) begin
      mem[idx] <= ramstore;
    end
  end

endmodule

// File: rtl/memory_control.sv
// ----------------------------------------
// memory control
// round-robin ram arbiter and msi snoop fsm
// for two cores sharing one word-wide ram
// ----------------------------------------

module memory_control (
  input  logic                           CLK,
  input  logic                           nRST,
  // cache side, indexed by core
  input  logic [coherence_pkg::CPUS-1:0] iren,
  input  logic [coherence_pkg::CPUS-1:0] dren,
  input  logic [coherence_pkg::CPUS-1:0] dwen,
  input  logic [coherence_pkg::CPUS-1:0] ccwrite,
  input  logic [coherence_pkg::CPUS-1:0] cctrans,
  input  coherence_pkg::addr_t           iaddr [coherence_pkg::CPUS],
  input  coherence_pkg::addr_t           daddr [coherence_pkg::CPUS],
  input  coherence_pkg::word_t           dstore [coherence_pkg::CPUS],
  output logic [coherence_pkg::CPUS-1:0] iwait,
  output logic [coherence_pkg::CPUS-1:0] dwait,
  output logic [coherence_pkg::CPUS-1:0] ccwait,
  output logic [coherence_pkg::CPUS-1:0] ccinv,
  output coherence_pkg::word_t           iload [coherence_pkg::CPUS],
  output coherence_pkg::word_t           dload [coherence_pkg::CPUS],
  output coherence_pkg::addr_t           ccsnoopaddr [coherence_pkg::CPUS],
  // ram side
  input  coherence_pkg::word_t           ramload,
  input  coherence_pkg::ramstate_t       ramstate,
  output logic                           ramren,
  output logic                           ramwen,
  output coherence_pkg::addr_t           ramaddr,
  output coherence_pkg::word_t           ramstore
);

  import coherence_pkg::*;

  // control state
  mc_state_t state;
  mc_state_t next_state;
  logic      arb;
  logic      next_arb;
  logic      excl;
  logic      next_excl;

  // the core being snooped is always the other one
  logic      peer;
  logic      ram_done;

  // snooped modified line, kept for the transfer and the writeback
  logic      capture;
  addr_t     xfer_addr;
  word_t     xfer_word;

  assign peer     = ~arb;
  assign ram_done = (ramstate == ACCESS);

  // reply carrying a dirty word
  assign capture  = (state == SNOOP) && cctrans[peer] && ccwrite[peer];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      arb   <= 1'b0;
      excl  <= 1'b0;
    end else begin
      state <= next_state;
      arb   <= next_arb;
      excl  <= next_excl;
    end
  end

  // the snooper may drop the line once it has replied
  always_ff @(posedge CLK) begin
    if (capture) begin
      xfer_addr <= daddr[arb];
      xfer_word <= dstore[peer];
    end
  end

  always_comb begin
    next_state = state;
    next_arb   = arb;
    next_excl  = excl;

    case (state)
      IDLE: begin
        // data before fetch, only core arb is looked at
        if (dwen[arb]) begin
          next_state = WB;
        end else if (dren[arb]) begin
          next_state = SNOOP;
          // ccwrite with dren marks busrdx
          next_excl  = ccwrite[arb];
        end else if (iren[arb]) begin
          next_state = IFETCH;
        end else begin
          // nothing pending, try the other core
          next_arb = peer;
        end
      end
      IFETCH, MEM_RD, WB: begin
        if (ram_done) begin
          next_state = IDLE;
        end
      end
      SNOOP: begin
        // wait for the peer to answer
        if (cctrans[peer]) begin
          next_state = ccwrite[peer] ? XFER : MEM_RD;
        end
      end
      XFER: begin
        // a bus read leaves the line shared, so ram must be updated
        next_state = excl ? IDLE : XFER_WB;
      end
      XFER_WB: begin
        if (ram_done) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase

    // transaction finished, hand over to the other core
    if ((state != IDLE) && (next_state == IDLE)) begin
      next_arb = peer;
    end
  end

  always_comb begin
    // everything idle unless a state says otherwise
    iwait    = '1;
    dwait    = '1;
    ccwait   = '0;
    ccinv    = '0;
    for (int c = 0; c < CPUS; c++) begin
      iload[c]       = '0;
      dload[c]       = '0;
      ccsnoopaddr[c] = '0;
    end
    ramren   = 1'b0;
    ramwen   = 1'b0;
    ramaddr  = '0;
    ramstore = '0;

    case (state)
      IFETCH: begin
        ramren      = 1'b1;
        ramaddr     = iaddr[arb];
        iload[arb]  = ramload;
        iwait[arb]  = ~ram_done;
      end
      SNOOP: begin
        ccwait[peer]      = 1'b1;
        ccsnoopaddr[peer] = daddr[arb];
        // invalidate the peer copy on the reply to busrdx
        ccinv[peer]       = cctrans[peer] & excl;
      end
      MEM_RD: begin
        // clean line, ram supplies it
        ramren      = 1'b1;
        ramaddr     = daddr[arb];
        dload[arb]  = ramload;
        dwait[arb]  = ~ram_done;
      end
      XFER: begin
        // cache to cache, one cycle
        dload[arb]  = xfer_word;
        dwait[arb]  = 1'b0;
      end
      XFER_WB: begin
        // no pulse to anyone here
        ramwen      = 1'b1;
        ramaddr     = xfer_addr;
        ramstore    = xfer_word;
      end
      WB: begin
        ramwen      = 1'b1;
        ramaddr     = daddr[arb];
        ramstore    = dstore[arb];
        dwait[arb]  = ~ram_done;
      end
      default: begin
      end
    endcase
  end

endmodule

// File: rtl/coherent_mem_top.sv
// ----------------------------------------
// coherent memory top
// bus controller plus shared ram
// ----------------------------------------

module coherent_mem_top (
  input  logic                           CLK,
  input  logic                           nRST,
  input  logic [coherence_pkg::CPUS-1:0] iren,
  input  logic [coherence_pkg::CPUS-1:0] dren,
  input  logic [coherence_pkg::CPUS-1:0] dwen,
  input  logic [coherence_pkg::CPUS-1:0] ccwrite,
  input  logic [coherence_pkg::CPUS-1:0] cctrans,
  input  coherence_pkg::addr_t           iaddr [coherence_pkg::CPUS],
  input  coherence_pkg::addr_t           daddr [coherence_pkg::CPUS],
  input  coherence_pkg::word_t           dstore [coherence_pkg::CPUS],
  output logic [coherence_pkg::CPUS-1:0] iwait,
  output logic [coherence_pkg::CPUS-1:0] dwait,
  output logic [coherence_pkg::CPUS-1:0] ccwait,
  output logic [coherence_pkg::CPUS-1:0] ccinv,
  output coherence_pkg::word_t           iload [coherence_pkg::CPUS],
  output coherence_pkg::word_t           dload [coherence_pkg::CPUS],
  output coherence_pkg::addr_t           ccsnoopaddr [coherence_pkg::CPUS]
);

  import coherence_pkg::*;

  // ram bus, internal only
  logic      ramren;
  logic      ramwen;
  addr_t     ramaddr;
  word_t     ramstore;
  word_t     ramload;
  ramstate_t ramstate;

  memory_control mc0 (
    .CLK, .nRST,
    .iren, .dren, .dwen, .ccwrite, .cctrans,
    .iaddr, .daddr, .dstore,
    .iwait, .dwait, .ccwait, .ccinv,
    .iload, .dload, .ccsnoopaddr,
    .ramload, .ramstate,
    .ramren, .ramwen, .ramaddr, .ramstore
  );

  ram_model ram0 (
    .CLK, .nRST,
    .ramren, .ramwen, .ramaddr, .ramstore,
    .ramload, .ramstate
  );

endmodule

// File: test/tb_coherent_mem.sv
// ----------------------------------------
// coherent memory testbench
// two random cache agents against a model
// ----------------------------------------

module tb_coherent_mem;
  timeunit 1ns;
  timeprecision 1ps;

  import coherence_pkg::*;

  localparam int OPS   = 300;
  localparam int LINES = 8;
  localparam int SEED  = 73;
  // ops of both cores at 40 cycles of 8 ns each
  localparam int TIMEOUT_NS = 2 * OPS * 40 * 8;

  typedef enum logic [1:0] {ST_I, ST_S, ST_M} line_st_t;
  typedef enum logic [1:0] {OP_FETCH, OP_RD, OP_RDX, OP_WB} op_t;

  logic            CLK;
  logic            nRST;
  logic [CPUS-1:0] iren;
  logic [CPUS-1:0] dren;
  logic [CPUS-1:0] dwen;
  logic [CPUS-1:0] ccwrite;
  logic [CPUS-1:0] cctrans;
  addr_t           iaddr [CPUS];
  addr_t           daddr [CPUS];
  word_t           dstore [CPUS];
  logic [CPUS-1:0] iwait;
  logic [CPUS-1:0] dwait;
  logic [CPUS-1:0] ccwait;
  logic [CPUS-1:0] ccinv;
  word_t           iload [CPUS];
  word_t           dload [CPUS];
  addr_t           ccsnoopaddr [CPUS];

  // request and snoop reply share ccwrite and dstore
  logic [CPUS-1:0] req_x;
  logic [CPUS-1:0] reply_wr;
  word_t           req_data [CPUS];
  word_t           reply_data [CPUS];

  // ram shadow plus one line table per core
  word_t           shadow [LINES];
  line_st_t        line_st [CPUS][LINES];
  word_t           line_val [CPUS][LINES];
  // what the snooped core told each requester
  logic [CPUS-1:0] reply_m;
  word_t           reply_val [CPUS];
  int              inv_cnt [CPUS];

  assign ccwrite   = (cctrans & reply_wr) | (~cctrans & req_x);
  assign dstore[0] = cctrans[0] ? reply_data[0] : req_data[0];
  assign dstore[1] = cctrans[1] ? reply_data[1] : req_data[1];

  coherent_mem_top dut0 (
    .CLK, .nRST,
    .iren, .dren, .dwen, .ccwrite, .cctrans,
    .iaddr, .daddr, .dstore,
    .iwait, .dwait, .ccwait, .ccinv,
    .iload, .dload, .ccsnoopaddr
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // test lines are consecutive words from 0x100
  function automatic addr_t addr_of(input int k);
    return addr_t'(32'h100 + 4 * k);
  endfunction

  function automatic int line_of(input addr_t a);
    return int'(a[4:2]);
  endfunction

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  // bus outputs all inactive
  task automatic verify_idle_outputs();
    check_equal("iwait", 32'(iwait), 32'(2'b11));
    check_equal("dwait", 32'(dwait), 32'(2'b11));
    check_equal("ccwait", 32'(ccwait), 32'(0));
    check_equal("ccinv", 32'(ccinv), 32'(0));
  endtask

  // snoop side rules checked on every edge
  always @(posedge CLK) begin
    if (nRST) begin
      for (int c = 0; c < CPUS; c++) begin
        if (ccwait[c]) begin
          check_equal($sformatf("ccwait[%0d]", 1 - c), 32'(ccwait[1-c]), 32'(0));
          check_equal($sformatf("dren[%0d]", 1 - c), 32'(dren[1-c]), 32'(1));
          check_equal($sformatf("ccsnoopaddr[%0d]", c), ccsnoopaddr[c], daddr[1-c]);
        end
        if (ccinv[c]) begin
          // only legal in a snoop reply cycle
          check_equal($sformatf("ccwait&cctrans[%0d] at ccinv", c),
                      32'(ccwait[c] & cctrans[c]), 32'(1));
          inv_cnt[c]++;
        end
      end
    end
  end

  // answer snoops from this core's line table
  task automatic respond(input int c);
    int   k;
    logic m;
    forever begin
      @(posedge CLK);
      if (ccwait[c]) begin
        k = line_of(ccsnoopaddr[c]);
        repeat ($urandom_range(2, 0)) @(posedge CLK);
        @(negedge CLK);
        m             = (line_st[c][k] == ST_M);
        reply_wr[c]   = m;
        reply_data[c] = line_val[c][k];
        cctrans[c]    = 1'b1;
        @(posedge CLK);
        reply_m[1-c]   = m;
        reply_val[1-c] = line_val[c][k];
        if (ccinv[c]) begin
          line_st[c][k] = ST_I;
        end else if (m) begin
          // a bus read of a dirty line also updates ram
          line_st[c][k] = ST_S;
          shadow[k]     = line_val[c][k];
        end
        @(negedge CLK);
        cctrans[c]  = 1'b0;
        reply_wr[c] = 1'b0;
      end
    end
  endtask

  task automatic run_agent(input int c);
    int       k;
    int       inv_start;
    op_t      op;
    line_st_t st;
    word_t    exp_w;
    for (int n = 0; n < OPS; n++) begin
      k  = $urandom_range(LINES - 1, 0);
      st = line_st[c][k];
      case ($urandom_range(3, 0))
        0: op = OP_FETCH;
        1: op = (st == ST_I) ? OP_RD : OP_FETCH;
        default: op = (st == ST_M) ? OP_WB : OP_RDX;
      endcase
      @(negedge CLK);
      inv_start  = inv_cnt[1-c];
      reply_m[c] = 1'b0;
      case (op)
        OP_FETCH: begin
          iaddr[c] = addr_of(k);
          iren[c]  = 1'b1;
        end
        OP_WB: begin
          daddr[c]    = addr_of(k);
          req_data[c] = line_val[c][k];
          dwen[c]     = 1'b1;
        end
        default: begin
          // ccwrite with dren asks for exclusive
          daddr[c] = addr_of(k);
          req_x[c] = (op == OP_RDX);
          dren[c]  = 1'b1;
        end
      endcase
      do begin
        @(posedge CLK);
      end while ((op == OP_FETCH) ? iwait[c] : dwait[c]);
      // dirty peer data takes precedence over ram
      exp_w = reply_m[c] ? reply_val[c] : shadow[k];
      case (op)
        OP_FETCH: begin
          check_equal($sformatf("iload[%0d]", c), iload[c], shadow[k]);
        end
        OP_WB: begin
          shadow[k]     = req_data[c];
          line_st[c][k] = ST_I;
        end
        default: begin
          check_equal($sformatf("dload[%0d]", c), dload[c], exp_w);
          if (op == OP_RD) begin
            line_st[c][k]  = ST_S;
            line_val[c][k] = exp_w;
          end else begin
            // local store after the upgrade
            line_st[c][k]  = ST_M;
            line_val[c][k] = $urandom();
          end
        end
      endcase
      check_equal($sformatf("ccinv[%0d] pulses", 1 - c),
                  32'(inv_cnt[1-c] - inv_start), 32'(op == OP_RDX));
      @(negedge CLK);
      iren[c]  = 1'b0;
      dren[c]  = 1'b0;
      dwen[c]  = 1'b0;
      req_x[c] = 1'b0;
      repeat ($urandom_range(2, 0)) @(negedge CLK);
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the agents did not finish their operations in time");
    $display("TB FAILED");
    $fatal(1, "watchdog");
  end

  initial begin
    void'($urandom(SEED));
    nRST     = 1'b0;
    iren     = '0;
    dren     = '0;
    dwen     = '0;
    cctrans  = '0;
    req_x    = '0;
    reply_wr = '0;
    reply_m  = '0;
    for (int c = 0; c < CPUS; c++) begin
      iaddr[c]      = '0;
      daddr[c]      = '0;
      req_data[c]   = '0;
      reply_data[c] = '0;
      reply_val[c]  = '0;
      inv_cnt[c]    = 0;
      for (int k = 0; k < LINES; k++) begin
        line_st[c][k]  = ST_I;
        line_val[c][k] = '0;
      end
    end
    for (int k = 0; k < LINES; k++) begin
      shadow[k] = '0;
    end
    repeat (3) begin
      @(posedge CLK);
      verify_idle_outputs();
    end
    @(negedge CLK);
    nRST = 1'b1;
    repeat (2) begin
      @(posedge CLK);
      verify_idle_outputs();
    end
    // agents and snoop responders run side by side
    fork
      begin
        fork
          run_agent(0);
          run_agent(1);
        join
      end
      respond(0);
      respond(1);
    join_any
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: coherent_mem_top.f
rtl/coherence_pkg.sv
rtl/ram_model.sv
rtl/memory_control.sv
rtl/coherent_mem_top.sv
test/tb_coherent_mem.sv

// File: Bender.yml
package:
  name: coherent_mem

sources:
  - rtl/coherence_pkg.sv
  - rtl/ram_model.sv
  - rtl/memory_control.sv
  - rtl/coherent_mem_top.sv
  - target: test
    files:
      - test/tb_coherent_mem.sv
